// ==== valu_defs.svh ====
/*
 * Global sizes of the vector ALU lane
 *   datapath and byte-enable widths
 *   instruction id space, queue depths
 *   register-file geometry seen by one lane
 */

`ifndef VALU_DEFS_SVH
`define VALU_DEFS_SVH

//////////////////////////////////////////////////
// Datapath
//////////////////////////////////////////////////

// One register-file word, always operated on as a whole
`define VALU_ELEN 64
`define VALU_STRB 8

//////////////////////////////////////////////////
// Queues and ids
//////////////////////////////////////////////////

`define VALU_NR_VINSN 8
// Both depths are powers of two so pointers wrap on their own
`define VALU_INSN_DEPTH 4
`define VALU_RQ_DEPTH 2

//////////////////////////////////////////////////
// Register file
//////////////////////////////////////////////////

`define VALU_VL_WIDTH 8
`define VALU_VREG_WORDS 32
`define VALU_ADDR_WIDTH 10

`endif

// ==== valu_pkg.sv ====
/*
 * Shared types of the vector ALU lane
 *   opcode and element-width enums
 *   instruction, result and result-queue entry structs
 *   element count and byte-enable helpers
 */

`default_nettype none

`include "valu_defs.svh"

package valu_pkg;

  //////////////////////////////////////////////////
  // Scalar types
  //////////////////////////////////////////////////

  typedef logic [`VALU_ELEN-1:0]              elen_t;
  typedef logic [`VALU_STRB-1:0]              strb_t;
  typedef logic [$clog2(`VALU_NR_VINSN)-1:0]  vid_t;
  typedef logic [`VALU_VL_WIDTH-1:0]          vlen_t;
  typedef logic [`VALU_ADDR_WIDTH-1:0]        vaddr_t;

  // Element-wise integer ops
  typedef enum logic [3:0] {
    VADD, VSUB, VAND, VOR, VXOR, VMIN, VMAX, VMINU, VMAXU
  } valu_op_e;

  // Encoding doubles as log2 of the element size in bytes
  typedef enum logic [1:0] {
    EW8, EW16, EW32, EW64
  } vew_e;

  //////////////////////////////////////////////////
  // Structs
  //////////////////////////////////////////////////

  typedef struct packed {
    vid_t       id;
    valu_op_e   op;
    vew_e       vsew;
    vlen_t      vl;
    logic [4:0] vd;
    // Operand a comes from the scalar instead of vs1
    logic       use_scalar;
    elen_t      scalar;
    // Unmasked when set
    logic       vm;
  } valu_insn_t;

  // One register-file write
  typedef struct packed {
    vid_t   id;
    vaddr_t addr;
    elen_t  wdata;
    strb_t  be;
  } valu_result_t;

  typedef struct packed {
    valu_result_t res;
    // Final word of its instruction
    logic         last;
  } valu_rq_entry_t;

  //////////////////////////////////////////////////
  // Helpers
  //////////////////////////////////////////////////

  // Elements held in one 64-bit word
  function automatic vlen_t elems_per_word(vew_e vsew);
    return vlen_t'(8) >> vsew;
  endfunction

  // Low bytes covering the first n elements of the word
  function automatic strb_t be_for_count(vlen_t n, vew_e vsew);
    strb_t be;
    for (int b = 0; b < `VALU_STRB; b++) begin
      // Byte b belongs to element b >> vsew
      be[b] = (b >> vsew) < int'(n);
    end
    return be;
  endfunction

endpackage

`default_nettype wire

// ==== valu_simd_alu.sv ====
/*
 * SIMD integer datapath
 *   add, sub, bitwise and/or/xor, signed and unsigned min/max
 *   8, 16, 32 and 64-bit elements on one 64-bit word
 */

`default_nettype none

`include "valu_defs.svh"

module valu_simd_alu (
  input  valu_pkg::valu_op_e op_i,
  input  valu_pkg::vew_e     vew_i,
  // Operand a is vs1 or the scalar, operand b is vs2
  input  valu_pkg::elen_t    operand_a_i,
  input  valu_pkg::elen_t    operand_b_i,
  output valu_pkg::elen_t    result_o
);

  import valu_pkg::*;

  //////////////////////////////////////////////////
  // One element
  //////////////////////////////////////////////////

  // Operands arrive zero-extended from w bits
  // Only the low w bits of the return value are kept
  function automatic elen_t elem_op(valu_op_e op, elen_t a, elen_t b, int unsigned w);
    elen_t sb;
    logic  lt_s;
    logic  lt_u;
    sb   = elen_t'(1) << (w - 1);
    // Flipping the sign bit turns a signed compare into an unsigned one
    lt_s = (a ^ sb) < (b ^ sb);
    lt_u = a < b;
    case (op)
      VADD:    return b + a;
      VSUB:    return b - a;
      VAND:    return b & a;
      VOR:     return b | a;
      VXOR:    return b ^ a;
      VMIN:    return lt_s ? a : b;
      VMAX:    return lt_s ? b : a;
      VMINU:   return lt_u ? a : b;
      VMAXU:   return lt_u ? b : a;
      default: return '0;
    endcase
  endfunction

  //////////////////////////////////////////////////
  // All widths in parallel
  //////////////////////////////////////////////////

  elen_t res_w [4];

  for (genvar g = 0; g < 4; g++) begin : gen_width
    localparam int unsigned W = 8 << g;

    always_comb begin
      elen_t tmp;
      for (int e = 0; e < `VALU_ELEN / W; e++) begin
        // Carries stop at the element boundary, so each lane wraps
        tmp = elem_op(op_i,
                      elen_t'(operand_a_i[e*W +: W]),
                      elen_t'(operand_b_i[e*W +: W]),
                      W);
        res_w[g][e*W +: W] = tmp[W-1:0];
      end
    end
  end

  // vew encoding is the index of the matching width
  assign result_o = res_w[vew_i];

endmodule

`default_nettype wire

// ==== valu_insn_queue.sv ====
/*
 * Instruction queue of the vector ALU lane
 *   circular buffer with accept, issue and commit pointers
 *   slots free on commit only
 *   registered done pulse per instruction id
 */

`default_nettype none

`include "valu_defs.svh"

module valu_insn_queue (
  input  wire                       clk_i,
  input  wire                       rst_ni,
  // From the dispatcher
  input  valu_pkg::valu_insn_t      insn_i,
  input  wire                       insn_valid_i,
  output logic                      insn_ready_o,
  // To the issue sequencer
  output valu_pkg::valu_insn_t      issue_insn_o,
  output logic                      issue_valid_o,
  input  wire                       issue_ready_i,
  // From the result queue
  input  wire                       commit_i,
  output logic [`VALU_NR_VINSN-1:0] done_o
);

  import valu_pkg::*;

  localparam int unsigned Depth = `VALU_INSN_DEPTH;
  localparam int unsigned PntW  = $clog2(Depth);

  //////////////////////////////////////////////////
  // Storage and pointers
  //////////////////////////////////////////////////

  valu_insn_t mem_q [Depth];

  logic [PntW-1:0] accept_pnt_q, issue_pnt_q, commit_pnt_q;
  // Instructions waiting for issue, and for their last write
  logic [PntW:0]   issue_cnt_q, commit_cnt_q;

  logic [`VALU_NR_VINSN-1:0] done_d, done_q;

  logic full;
  logic accept;
  logic issue;

  // Full counts uncommitted work, not unissued work
  assign full         = commit_cnt_q == (PntW+1)'(Depth);
  assign insn_ready_o = !full;
  assign accept       = insn_valid_i && insn_ready_o;

  assign issue_valid_o = issue_cnt_q != '0;
  assign issue_insn_o  = mem_q[issue_pnt_q];
  assign issue         = issue_valid_o && issue_ready_i;

  always_ff @(posedge clk_i) begin
    if (accept) begin
      mem_q[accept_pnt_q] <= insn_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      accept_pnt_q <= '0;
      issue_pnt_q  <= '0;
      commit_pnt_q <= '0;
      issue_cnt_q  <= '0;
      commit_cnt_q <= '0;
    end else begin
      accept_pnt_q <= accept_pnt_q + PntW'(accept);
      issue_pnt_q  <= issue_pnt_q + PntW'(issue);
      commit_pnt_q <= commit_pnt_q + PntW'(commit_i);
      issue_cnt_q  <= issue_cnt_q + (PntW+1)'(accept) - (PntW+1)'(issue);
      commit_cnt_q <= commit_cnt_q + (PntW+1)'(accept) - (PntW+1)'(commit_i);
    end
  end

  //////////////////////////////////////////////////
  // Done
  //////////////////////////////////////////////////

  // Commits come in acceptance order, so the oldest id is the one done
  always_comb begin
    done_d = '0;
    if (commit_i) begin
      done_d[mem_q[commit_pnt_q].id] = 1'b1;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      done_q <= '0;
    end else begin
      done_q <= done_d;
    end
  end

  assign done_o = done_q;

  // Zero-length vectors would never produce a last word
  a_vl_nonzero : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    accept |-> insn_i.vl != '0
  ) else $error("instruction accepted with vl of zero");

  // Result queue must not retire more instructions than were accepted
  a_commit_pending : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    commit_i |-> commit_cnt_q != '0
  ) else $error("commit with no instruction outstanding");

endmodule

`default_nettype wire

// ==== valu_issue.sv ====
/*
 * Issue sequencer of the vector ALU lane
 *   element and word counters of the current instruction
 *   operand and mask handshakes, scalar replication
 *   address and byte enables of each result word
 */

`default_nettype none

`include "valu_defs.svh"

module valu_issue (
  input  wire                       clk_i,
  input  wire                       rst_ni,
  // Head of the instruction queue
  input  valu_pkg::valu_insn_t      insn_i,
  input  wire                       insn_valid_i,
  output logic                      insn_ready_o,
  // Operand queues, index 1 is vs2 and index 0 is vs1
  input  valu_pkg::elen_t [1:0]     operand_i,
  input  wire             [1:0]     operand_valid_i,
  output logic            [1:0]     operand_ready_o,
  // Mask, one bit per byte
  input  valu_pkg::strb_t           mask_i,
  input  wire                       mask_valid_i,
  output logic                      mask_ready_o,
  // To the result queue
  output valu_pkg::valu_rq_entry_t  entry_o,
  output logic                      entry_valid_o,
  input  wire                       entry_ready_i
);

  import valu_pkg::*;

  localparam int unsigned VregWords = `VALU_VREG_WORDS;

  //////////////////////////////////////////////////
  // Counters
  //////////////////////////////////////////////////

  // Set while the counters hold a partly issued instruction
  logic  active_q;
  vlen_t rem_q, word_q;

  vlen_t rem_cur, word_cur;
  vlen_t epw, n_elem, rem_next;

  // First word of an instruction takes its counts straight from the queue
  assign rem_cur  = active_q ? rem_q : insn_i.vl;
  assign word_cur = active_q ? word_q : '0;

  assign epw      = elems_per_word(insn_i.vsew);
  assign n_elem   = (rem_cur < epw) ? rem_cur : epw;
  assign rem_next = rem_cur - n_elem;

  //////////////////////////////////////////////////
  // Handshakes
  //////////////////////////////////////////////////

  logic fire;

  // Valid does not wait on the result queue
  assign entry_valid_o = insn_valid_i && operand_valid_i[1]
                      && (operand_valid_i[0] || insn_i.use_scalar)
                      && (mask_valid_i || insn_i.vm);
  assign fire          = entry_valid_o && entry_ready_i;

  assign operand_ready_o = {fire, fire && !insn_i.use_scalar};
  assign mask_ready_o    = fire && !insn_i.vm;
  // Pops the instruction together with its last word
  assign insn_ready_o    = fire && (rem_next == '0);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      active_q <= 1'b0;
      rem_q    <= '0;
      word_q   <= '0;
    end else if (fire) begin
      active_q <= rem_next != '0;
      rem_q    <= rem_next;
      word_q   <= word_cur + vlen_t'(1);
    end
  end

  //////////////////////////////////////////////////
  // Datapath
  //////////////////////////////////////////////////

  elen_t scalar_rep;
  elen_t operand_a;
  elen_t alu_result;

  // Scalar copied into every element of the word
  always_comb begin
    case (insn_i.vsew)
      EW8:     scalar_rep = {8{insn_i.scalar[7:0]}};
      EW16:    scalar_rep = {4{insn_i.scalar[15:0]}};
      EW32:    scalar_rep = {2{insn_i.scalar[31:0]}};
      default: scalar_rep = insn_i.scalar;
    endcase
  end

  assign operand_a = insn_i.use_scalar ? scalar_rep : operand_i[0];

  valu_simd_alu i_valu_simd_alu (
    .op_i        (insn_i.op),
    .vew_i       (insn_i.vsew),
    .operand_a_i (operand_a),
    .operand_b_i (operand_i[1]),
    .result_o    (alu_result)
  );

  always_comb begin
    entry_o.res.id    = insn_i.id;
    // Each vector register owns a block of words in this lane
    entry_o.res.addr  = vaddr_t'(insn_i.vd) * vaddr_t'(VregWords) + vaddr_t'(word_cur);
    entry_o.res.wdata = alu_result;
    // Partial last word, then the element mask
    entry_o.res.be    = be_for_count(n_elem, insn_i.vsew) & (insn_i.vm ? '1 : mask_i);
    entry_o.last      = rem_next == '0;
  end

  // Operand and mask sources must hold their words while stalled
  a_entry_stable : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    entry_valid_o && !entry_ready_i |=> entry_valid_o && $stable(entry_o)
  ) else $error("result entry changed while stalled");

endmodule

`default_nettype wire

// ==== valu_result_queue.sv ====
/*
 * Result queue of the vector ALU lane
 *   small FIFO of result words
 *   req/gnt write port to the register file
 *   commit strobe on the last word of an instruction
 */

`default_nettype none

`include "valu_defs.svh"

module valu_result_queue (
  input  wire                       clk_i,
  input  wire                       rst_ni,
  // From the issue sequencer
  input  valu_pkg::valu_rq_entry_t  entry_i,
  input  wire                       entry_valid_i,
  output logic                      entry_ready_o,
  // Register-file write port
  output valu_pkg::valu_result_t    result_o,
  output logic                      result_req_o,
  input  wire                       result_gnt_i,
  // To the instruction queue
  output logic                      commit_o
);

  import valu_pkg::*;

  localparam int unsigned Depth = `VALU_RQ_DEPTH;
  localparam int unsigned PntW  = $clog2(Depth);

  //////////////////////////////////////////////////
  // FIFO state
  //////////////////////////////////////////////////

  valu_rq_entry_t mem_q [Depth];

  logic [PntW-1:0] wr_pnt_q, rd_pnt_q;
  logic [PntW:0]   cnt_q;

  logic push;
  logic pop;

  // No write-through when full, issue simply stalls
  assign entry_ready_o = cnt_q != (PntW+1)'(Depth);
  assign push          = entry_valid_i && entry_ready_o;

  // Head stays put until granted
  assign result_req_o = cnt_q != '0;
  assign result_o     = mem_q[rd_pnt_q].res;
  assign pop          = result_req_o && result_gnt_i;
  assign commit_o     = pop && mem_q[rd_pnt_q].last;

  always_ff @(posedge clk_i) begin
    if (push) begin
      mem_q[wr_pnt_q] <= entry_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_pnt_q <= '0;
      rd_pnt_q <= '0;
      cnt_q    <= '0;
    end else begin
      wr_pnt_q <= wr_pnt_q + PntW'(push);
      rd_pnt_q <= rd_pnt_q + PntW'(pop);
      cnt_q    <= cnt_q + (PntW+1)'(push) - (PntW+1)'(pop);
    end
  end

  // Register file only grants an outstanding request
  a_gnt_with_req : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    result_gnt_i |-> result_req_o
  ) else $error("grant without request");

endmodule

`default_nettype wire

// ==== valu_top.sv ====
/*
 * Vector integer ALU of one lane
 *   instruction queue, issue sequencer with SIMD datapath,
 *   result queue toward the register file
 */

`default_nettype none

`include "valu_defs.svh"

module valu_top (
  input  wire                       clk_i,
  input  wire                       rst_ni,
  // Instructions
  input  valu_pkg::valu_insn_t      insn_i,
  input  wire                       insn_valid_i,
  output logic                      insn_ready_o,
  // Operands, index 1 is vs2 and index 0 is vs1
  input  valu_pkg::elen_t [1:0]     operand_i,
  input  wire             [1:0]     operand_valid_i,
  output logic            [1:0]     operand_ready_o,
  // Mask
  input  valu_pkg::strb_t           mask_i,
  input  wire                       mask_valid_i,
  output logic                      mask_ready_o,
  // Register-file write port
  output valu_pkg::valu_result_t    result_o,
  output logic                      result_req_o,
  input  wire                       result_gnt_i,
  // One pulse per finished instruction
  output logic [`VALU_NR_VINSN-1:0] done_o
);

  import valu_pkg::*;

  // Queue head toward the sequencer
  valu_insn_t     issue_insn;
  logic           issue_valid;
  logic           issue_ready;

  // Sequencer toward the result queue
  valu_rq_entry_t entry;
  logic           entry_valid;
  logic           entry_ready;

  logic           commit;

  valu_insn_queue i_valu_insn_queue (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .insn_i        (insn_i),
    .insn_valid_i  (insn_valid_i),
    .insn_ready_o  (insn_ready_o),
    .issue_insn_o  (issue_insn),
    .issue_valid_o (issue_valid),
    .issue_ready_i (issue_ready),
    .commit_i      (commit),
    .done_o        (done_o)
  );

  valu_issue i_valu_issue (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .insn_i          (issue_insn),
    .insn_valid_i    (issue_valid),
    .insn_ready_o    (issue_ready),
    .operand_i       (operand_i),
    .operand_valid_i (operand_valid_i),
    .operand_ready_o (operand_ready_o),
    .mask_i          (mask_i),
    .mask_valid_i    (mask_valid_i),
    .mask_ready_o    (mask_ready_o),
    .entry_o         (entry),
    .entry_valid_o   (entry_valid),
    .entry_ready_i   (entry_ready)
  );

  valu_result_queue i_valu_result_queue (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .entry_i       (entry),
    .entry_valid_i (entry_valid),
    .entry_ready_o (entry_ready),
    .result_o      (result_o),
    .result_req_o  (result_req_o),
    .result_gnt_i  (result_gnt_i),
    .commit_o      (commit)
  );

endmodule

`default_nettype wire

// ==== tb_valu.sv ====
/*
 * Testbench of the vector ALU lane
 *   clock, reset, instruction, operand and mask feeders
 *   grant driver with back-pressure, lane-wise reference model
 *   compare process for result words and done pulses
 */

`default_nettype none

`include "valu_defs.svh"

module tb_valu;

  timeunit 1ns;
  timeprecision 1ps;

  import valu_pkg::*;

  logic                      clk_i;
  logic                      rst_ni;
  valu_insn_t                insn_i;
  logic                      insn_valid_i;
  logic                      insn_ready_o;
  elen_t [1:0]               operand_i;
  logic  [1:0]               operand_valid_i;
  logic  [1:0]               operand_ready_o;
  strb_t                     mask_i;
  logic                      mask_valid_i;
  logic                      mask_ready_o;
  valu_result_t              result_o;
  logic                      result_req_o;
  logic                      result_gnt_i;
  logic [`VALU_NR_VINSN-1:0] done_o;

  // Words waiting to be handed to the DUT
  valu_insn_t   insn_q [$];
  elen_t        vs2_q [$];
  elen_t        vs1_q [$];
  strb_t        mask_q [$];
  // Expected writes in acceptance order, and ids whose last word was granted
  valu_result_t exp_q [$];
  logic         exp_last_q [$];
  vid_t         pending_done_q [$];

  valu_op_e all_ops [9] = '{VADD, VSUB, VAND, VOR, VXOR, VMIN, VMAX, VMINU, VMAXU};

  int    seed;
  int    errs, test_errs, checks, tests_run, tests_failed;
  int    n_accepted;
  // 0 grants at once, 1 random stretches, 2 no grant
  int    gnt_mode;
  bit    abort;
  string cur_test;
  vid_t  next_id;

  valu_top i_valu_top (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .insn_i          (insn_i),
    .insn_valid_i    (insn_valid_i),
    .insn_ready_o    (insn_ready_o),
    .operand_i       (operand_i),
    .operand_valid_i (operand_valid_i),
    .operand_ready_o (operand_ready_o),
    .mask_i          (mask_i),
    .mask_valid_i    (mask_valid_i),
    .mask_ready_o    (mask_ready_o),
    .result_o        (result_o),
    .result_req_o    (result_req_o),
    .result_gnt_i    (result_gnt_i),
    .done_o          (done_o)
  );

  initial begin : clock_gen
    clk_i = 1'b0;
    forever #20 clk_i = ~clk_i;
  end

  //////////////////////////////////////////////////
  // Reference model
  //////////////////////////////////////////////////

  // Each element computed on its own, wrapping at the element width
  function automatic elen_t ref_word(valu_op_e op, vew_e vsew, elen_t a, elen_t b);
    int unsigned        w;
    elen_t              mask, ea, eb, r, res;
    logic signed [63:0] sa, sb;
    w    = 32'd8 << vsew;
    mask = (w == 64) ? '1 : (elen_t'(1) << w) - elen_t'(1);
    res  = '0;
    for (int unsigned e = 0; e < 64 / w; e++) begin
      ea = (a >> (e * w)) & mask;
      eb = (b >> (e * w)) & mask;
      // Sign-extend both elements for the signed compares
      sa = $signed(ea << (64 - w)) >>> (64 - w);
      sb = $signed(eb << (64 - w)) >>> (64 - w);
      case (op)
        VADD:    r = eb + ea;
        VSUB:    r = eb - ea;
        VAND:    r = eb & ea;
        VOR:     r = eb | ea;
        VXOR:    r = eb ^ ea;
        VMIN:    r = (sa < sb) ? ea : eb;
        VMAX:    r = (sa < sb) ? eb : ea;
        VMINU:   r = (ea < eb) ? ea : eb;
        VMAXU:   r = (ea < eb) ? eb : ea;
        default: r = '0;
      endcase
      res = res | ((r & mask) << (e * w));
    end
    return res;
  endfunction

  // Byte enables of the first n elements
  function automatic strb_t element_bytes(int n, vew_e vsew);
    int nbytes;
    nbytes = n << vsew;
    return strb_t'((16'd1 << nbytes) - 16'd1);
  endfunction

  //////////////////////////////////////////////////
  // Checks and bookkeeping
  //////////////////////////////////////////////////

  task automatic check_result(string name, valu_result_t exp, valu_result_t act);
    checks++;
    if (act !== exp) begin
      errs++;
      test_errs++;
      $write("[FAIL] %s: expected id=%0d addr=%h data=%h be=%h, ",
             name, exp.id, exp.addr, exp.wdata, exp.be);
      $display("actual id=%0d addr=%h data=%h be=%h",
               act.id, act.addr, act.wdata, act.be);
    end
  endtask

  task automatic check_done(string name, vid_t exp, vid_t act);
    checks++;
    if (act !== exp) begin
      errs++;
      test_errs++;
      $display("[FAIL] %s: done id expected %0d, actual %0d", name, exp, act);
    end
  endtask

  task automatic check_flag(string what, logic exp, logic act);
    checks++;
    if (act !== exp) begin
      errs++;
      test_errs++;
      $display("[FAIL] %s %s: expected %0b, actual %0b", cur_test, what, exp, act);
    end
  endtask

  task automatic start_test(string name);
    cur_test  = name;
    test_errs = 0;
  endtask

  task automatic end_test();
    tests_run++;
    if (test_errs == 0) begin
      $display("Test %s: ok", cur_test);
    end else begin
      tests_failed++;
      $display("Test %s: %0d errors", cur_test, test_errs);
    end
  endtask

  // Queue one instruction with its operands, masks and expected writes
  task automatic send_insn(valu_op_e op, vew_e vsew, int vl, logic use_scalar, logic vm);
    valu_insn_t   insn;
    valu_result_t r;
    elen_t        a, b;
    strb_t        m;
    int           esz, epw, rem, n, w;
    esz             = 1 << vsew;
    epw             = 8 / esz;
    insn.id         = next_id;
    insn.op         = op;
    insn.vsew       = vsew;
    insn.vl         = vlen_t'(vl);
    insn.vd         = 5'($random(seed));
    insn.use_scalar = use_scalar;
    insn.scalar     = {$random(seed), $random(seed)};
    insn.vm         = vm;
    next_id         = next_id + vid_t'(1);
    rem             = vl;
    w               = 0;
    while (rem > 0) begin
      n = (rem < epw) ? rem : epw;
      b = {$random(seed), $random(seed)};
      vs2_q.push_back(b);
      if (use_scalar) begin
        // Low element of the scalar copied into every element slot
        for (int k = 0; k < 8; k++) begin
          a[8*k +: 8] = insn.scalar[8*(k % esz) +: 8];
        end
      end else begin
        a = {$random(seed), $random(seed)};
        vs1_q.push_back(a);
      end
      r.id    = insn.id;
      r.addr  = vaddr_t'(int'(insn.vd) * `VALU_VREG_WORDS + w);
      r.wdata = ref_word(op, vsew, a, b);
      r.be    = element_bytes(n, vsew);
      if (!vm) begin
        m = strb_t'($random(seed));
        mask_q.push_back(m);
        r.be = r.be & m;
      end
      exp_q.push_back(r);
      exp_last_q.push_back(rem == n);
      rem = rem - n;
      w++;
    end
    insn_q.push_back(insn);
  endtask

  function automatic bit busy();
    return insn_q.size() != 0 || exp_q.size() != 0 || pending_done_q.size() != 0;
  endfunction

  // Every write granted and every done pulse seen
  task automatic wait_drained();
    int cycles;
    cycles = 0;
    while (busy() && cycles < 5000) begin
      @(negedge clk_i);
      cycles++;
    end
    if (busy()) begin
      errs++;
      test_errs++;
      abort = 1'b1;
      $display("ERROR: %s timed out with %0d writes and %0d done pulses outstanding",
               cur_test, exp_q.size(), pending_done_q.size());
    end
  endtask

  task automatic wait_accepted(int target);
    int cycles;
    cycles = 0;
    while (n_accepted < target && cycles < 200) begin
      @(negedge clk_i);
      cycles++;
    end
    if (n_accepted < target) begin
      errs++;
      test_errs++;
      abort = 1'b1;
      $display("ERROR: %s timed out waiting for instructions to be accepted", cur_test);
    end
  endtask

  //////////////////////////////////////////////////
  // Drivers and compare process
  //////////////////////////////////////////////////

  // Heads of the queues shown after each edge, popped on a handshake
  initial begin : feed_inputs
    forever begin
      @(posedge clk_i);
      #2;
      insn_valid_i       = insn_q.size() != 0;
      operand_valid_i[1] = vs2_q.size() != 0;
      operand_valid_i[0] = vs1_q.size() != 0;
      mask_valid_i       = mask_q.size() != 0;
      if (insn_valid_i) insn_i = insn_q[0];
      if (operand_valid_i[1]) operand_i[1] = vs2_q[0];
      if (operand_valid_i[0]) operand_i[0] = vs1_q[0];
      if (mask_valid_i) mask_i = mask_q[0];
      @(negedge clk_i);
      if (insn_valid_i && insn_ready_o) begin
        void'(insn_q.pop_front());
        n_accepted++;
      end
      if (operand_valid_i[1] && operand_ready_o[1]) void'(vs2_q.pop_front());
      if (operand_valid_i[0] && operand_ready_o[0]) void'(vs1_q.pop_front());
      if (mask_valid_i && mask_ready_o) void'(mask_q.pop_front());
    end
  end

  initial begin : drive_grant
    int   stretch;
    logic hold;
    stretch = 0;
    hold    = 1'b0;
    forever begin
      @(posedge clk_i);
      #2;
      if (gnt_mode == 0) begin
        result_gnt_i = result_req_o;
      end else if (gnt_mode == 1) begin
        // Alternate grant and stall stretches of random length
        if (stretch == 0) begin
          hold    = ~hold;
          stretch = 1 + int'($unsigned($random(seed)) % 6);
        end
        stretch--;
        result_gnt_i = result_req_o && !hold;
      end else begin
        result_gnt_i = 1'b0;
      end
    end
  end

  initial begin : compare_results
    valu_result_t exp;
    logic         last;
    forever begin
      @(negedge clk_i);
      // Done first, so a pulse in the cycle of its own last grant finds nothing pending
      for (int i = 0; i < `VALU_NR_VINSN; i++) begin
        if (done_o[i]) begin
          if (pending_done_q.size() == 0) begin
            errs++;
            test_errs++;
            $display("ERROR: %s done pulse for id %0d with no instruction finished",
                     cur_test, i);
          end else begin
            check_done(cur_test, pending_done_q.pop_front(), vid_t'(i));
          end
        end
      end
      if (result_req_o && result_gnt_i) begin
        if (exp_q.size() == 0) begin
          errs++;
          test_errs++;
          $display("ERROR: %s register-file write with no expected word", cur_test);
        end else begin
          exp  = exp_q.pop_front();
          last = exp_last_q.pop_front();
          check_result(cur_test, exp, result_o);
          if (last) pending_done_q.push_back(exp.id);
        end
      end
    end
  end

  //////////////////////////////////////////////////
  // Tests
  //////////////////////////////////////////////////

  task automatic test_all_ops();
    start_test("all_ops_vv");
    for (int s = 0; s < 4; s++) begin
      for (int o = 0; o < 9; o++) begin
        send_insn(all_ops[o], vew_e'(2'(s)), 2 * (8 >> s), 1'b0, 1'b1);
      end
    end
    wait_drained();
    end_test();
  endtask

  task automatic test_scalar();
    start_test("vector_scalar");
    // Stays at the vs1 head the whole test
    vs1_q.push_back(64'h0bad_f00d_dead_beef);
    for (int s = 0; s < 4; s++) begin
      for (int o = 0; o < 9; o += 2) begin
        send_insn(all_ops[o], vew_e'(2'(s)), (8 >> s) + 1, 1'b1, 1'b1);
      end
    end
    wait_drained();
    check_flag("vs1 left untouched", 1'b1, vs1_q.size() == 1);
    vs1_q.delete();
    end_test();
  endtask

  task automatic test_masked();
    start_test("masked");
    for (int s = 0; s < 4; s++) begin
      for (int o = 1; o < 9; o += 2) begin
        send_insn(all_ops[o], vew_e'(2'(s)), 3 * (8 >> s), 1'b0, 1'b0);
      end
      send_insn(VADD, vew_e'(2'(s)), 2 * (8 >> s), 1'b1, 1'b0);
    end
    wait_drained();
    end_test();
  endtask

  task automatic test_partial();
    start_test("partial_last");
    send_insn(VADD, EW8, 11, 1'b0, 1'b1);
    send_insn(VSUB, EW16, 5, 1'b0, 1'b1);
    send_insn(VMAX, EW32, 3, 1'b0, 1'b0);
    send_insn(VXOR, EW8, 1, 1'b1, 1'b1);
    for (int k = 0; k < 8; k++) begin
      send_insn(all_ops[$unsigned($random(seed)) % 9], vew_e'(2'($random(seed))),
                1 + int'($unsigned($random(seed)) % 20), 1'b0, 1'(k));
    end
    wait_drained();
    end_test();
  endtask

  task automatic test_backpressure();
    int base;
    start_test("backpressure");
    gnt_mode = 2;
    base     = n_accepted;
    for (int k = 0; k < 6; k++) begin
      send_insn(all_ops[k], vew_e'(2'(k)), 10, 1'(k % 2), 1'(k / 2 % 2));
    end
    wait_accepted(base + 4);
    repeat (4) @(negedge clk_i);
    // Nothing granted, so all four slots still wait for commit
    check_flag("insn_ready_o with four uncommitted", 1'b0, insn_ready_o);
    check_flag("fifth instruction held back", 1'b1, n_accepted == base + 4);
    gnt_mode = 1;
    wait_drained();
    gnt_mode = 0;
    end_test();
  endtask

  initial begin : run_tests
    seed            = 69;
    errs            = 0;
    checks          = 0;
    tests_run       = 0;
    tests_failed    = 0;
    n_accepted      = 0;
    gnt_mode        = 0;
    abort           = 1'b0;
    next_id         = '0;
    rst_ni          = 1'b0;
    insn_i          = '0;
    insn_valid_i    = 1'b0;
    operand_i       = '0;
    operand_valid_i = '0;
    mask_i          = '0;
    mask_valid_i    = 1'b0;
    result_gnt_i    = 1'b0;
    repeat (16) @(posedge clk_i);
    #2;
    rst_ni = 1'b1;
    @(negedge clk_i);

    // Idle outputs right after reset
    start_test("reset_state");
    check_flag("insn_ready_o", 1'b1, insn_ready_o);
    check_flag("result_req_o", 1'b0, result_req_o);
    check_flag("done_o", 1'b0, |done_o);
    check_flag("operand_ready_o", 1'b0, |operand_ready_o);
    check_flag("mask_ready_o", 1'b0, mask_ready_o);
    end_test();

    if (!abort) test_all_ops();
    if (!abort) test_scalar();
    if (!abort) test_masked();
    if (!abort) test_partial();
    if (!abort) test_backpressure();

    $display("Tests: %0d run, %0d failed, %0d checks, %0d errors",
             tests_run, tests_failed, checks, errs);
    if (errs == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== list.f ====
+incdir+.
valu_pkg.sv
valu_simd_alu.sv
valu_insn_queue.sv
valu_issue.sv
valu_result_queue.sv
valu_top.sv
tb_valu.sv

// ==== run.sh ====
#!/bin/sh
# Build the testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --timescale 1ns/1ps -j 0 --top-module tb_valu -f list.f \
  || { echo "run.sh: build failed"; exit 1; }
out=$(./obj_dir/Vtb_valu 2>&1)
echo "$out"
echo "$out" | grep -qx "STATUS: PASS" && echo "run.sh: simulation passed" \
  || { echo "run.sh: simulation failed"; exit 1; }
